// ==== dmb_trig_ctrl.f ====
+incdir+source
source/dmb_trig_pkg.sv
source/startup_sequencer.sv
source/trig_input_stage.sv
source/cfeb_trig_encoder.sv
source/trig_output_stage.sv
source/trg_timer.sv
source/dmb_trig_ctrl.sv
verification/tb_dmb_trig_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the trigger controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f dmb_trig_ctrl.f \
    --top-module tb_dmb_trig_ctrl \
    -o sim_tb_dmb_trig_ctrl

sim_output=$(./obj_dir/sim_tb_dmb_trig_ctrl)
echo "$sim_output"

if echo "$sim_output" | grep -qx "All tests passed"; then
    exit 0
else
    echo "Simulation reported a failure"
    exit 1
fi

// ==== source/cfeb_trig_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfeb_trig_encoder
(
	input  wire                      clkcms,
	input  wire                      fpga_rst_i,
	input  wire                      encode_i,
	input  wire                      lct_pulse_i,
	input  wire                      match_i,
	input  wire                      l1a_i,
	output dmb_trig_pkg::trig_code_t code_o
);

	dmb_trig_pkg::trig_code_t code_d;

	////////////////////////////////////////
	// Code selection
	////////////////////////////////////////

	always_comb
	begin
		if (!encode_i)
			// Raw mode passes the three flags straight through
			code_d = {l1a_i, match_i, lct_pulse_i};
		else if (l1a_i && match_i)
			code_d = 3'b101;
		else if (l1a_i)
			code_d = 3'b100;
		else if (lct_pulse_i)
			code_d = 3'b001;
		else
			code_d = 3'b000;
	end

	// Lane output register
	always_ff @(posedge clkcms or posedge fpga_rst_i)
	begin
		if (fpga_rst_i)
			code_o <= '0;
		else
			code_o <= code_d;
	end

endmodule

`default_nettype wire

// ==== source/dmb_trig_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dmb_trig_params.svh"

module dmb_trig_ctrl
(
	input  wire                      clkcms,
	input  wire                      clr0,
	input  wire                      ready_i,
	input  wire                      encode_i,
	input  wire                      cable_dly_i,
	input  wire                      readout_clr_i,
	input  wire                      l1a_i,
	input  dmb_trig_pkg::cfeb_mask_t pre_lct_i,
	input  dmb_trig_pkg::cfeb_mask_t l1a_match_i,
	input  dmb_trig_pkg::cfeb_mask_t cfeb_en_i,
	output dmb_trig_pkg::cfeb_mask_t trg_enc_b0_o,
	output dmb_trig_pkg::cfeb_mask_t trg_enc_b1_o,
	output dmb_trig_pkg::cfeb_mask_t trg_enc_b2_o,
	output logic                     ctrl_ready_o,
	output dmb_trig_pkg::lct_time_t  lct_time_o
);

	logic                                fpga_rst;
	logic                                holdoff;
	dmb_trig_pkg::cfeb_mask_t            lct_pulse;
	dmb_trig_pkg::cfeb_mask_t            match_q;
	logic                                l1a_q;
	logic                                lct_any;
	logic [`DMB_N_CFEB*`DMB_CODE_W-1:0]  codes;

	////////////////////////////////////////
	// Resets and holdoff
	////////////////////////////////////////

	startup_sequencer u_startup_sequencer
	(
		.clkcms       (clkcms),
		.clr0         (clr0),
		.ready_i      (ready_i),
		.fpga_rst_o   (fpga_rst),
		.holdoff_o    (holdoff),
		.ctrl_ready_o (ctrl_ready_o)
	);

	////////////////////////////////////////
	// Trigger encoding
	////////////////////////////////////////

	trig_input_stage u_trig_input_stage
	(
		.clkcms      (clkcms),
		.fpga_rst_i  (fpga_rst),
		.pre_lct_i   (pre_lct_i),
		.l1a_match_i (l1a_match_i),
		.cfeb_en_i   (cfeb_en_i),
		.l1a_i       (l1a_i),
		.lct_pulse_o (lct_pulse),
		.match_o     (match_q),
		.l1a_o       (l1a_q),
		.lct_any_o   (lct_any)
	);

	// One encoder per front-end board
	for (genvar g = 0; g < `DMB_N_CFEB; g++)
	begin : g_lane
		cfeb_trig_encoder u_cfeb_trig_encoder
		(
			.clkcms      (clkcms),
			.fpga_rst_i  (fpga_rst),
			.encode_i    (encode_i),
			.lct_pulse_i (lct_pulse[g]),
			.match_i     (match_q[g]),
			.l1a_i       (l1a_q),
			.code_o      (codes[g*`DMB_CODE_W +: `DMB_CODE_W])
		);
	end

	trig_output_stage u_trig_output_stage
	(
		.clkcms       (clkcms),
		.clr0         (clr0),
		.fpga_rst_i   (fpga_rst),
		.cable_dly_i  (cable_dly_i),
		.codes_i      (codes),
		.trg_enc_b0_o (trg_enc_b0_o),
		.trg_enc_b1_o (trg_enc_b1_o),
		.trg_enc_b2_o (trg_enc_b2_o)
	);

	// LCT to L1A latency
	trg_timer u_lct_l1a_timer
	(
		.clkcms    (clkcms),
		.clr0      (clr0),
		.holdoff_i (holdoff),
		.clr_i     (readout_clr_i),
		.start_i   (lct_any),
		.stop_i    (l1a_q),
		.time_o    (lct_time_o)
	);

endmodule

`default_nettype wire

// ==== source/dmb_trig_params.svh ====
`ifndef DMB_TRIG_PARAMS_SVH
`define DMB_TRIG_PARAMS_SVH

////////////////////////////////////////
// Trigger path sizes
////////////////////////////////////////

// Front-end boards served by this controller
`define DMB_N_CFEB 5
// Encoded bits per board on the trigger cable
`define DMB_CODE_W 3
// LCT to L1A latency timer
`define DMB_TIME_W 10

////////////////////////////////////////
// Startup sequence lengths in clkcms cycles
////////////////////////////////////////

// Internal reset pulse
`define DMB_FPGARST_CYCLES 16
// Internal reset end to controller ready
`define DMB_CRDY_CYCLES 64
// Internal reset end to end of power-on holdoff
`define DMB_POH_CYCLES 128
// Shared sequence counter
`define DMB_CNT_W 8

`endif

// ==== source/dmb_trig_pkg.sv ====
`default_nettype none

`include "dmb_trig_params.svh"

package dmb_trig_pkg;

	////////////////////////////////////////
	// Trigger path types
	////////////////////////////////////////

	// One bit per front-end board
	typedef logic [`DMB_N_CFEB-1:0] cfeb_mask_t;

	// Code sent to one board
	typedef logic [`DMB_CODE_W-1:0] trig_code_t;

	// Measured LCT to L1A latency
	typedef logic [`DMB_TIME_W-1:0] lct_time_t;

	// Startup sequence
	typedef enum logic [2:0]
	{
		wait_ready,
		fpga_rst,
		wait_crdy,
		holdoff,
		run
	} startup_state_t;

endpackage

`default_nettype wire

// ==== source/startup_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dmb_trig_params.svh"

module startup_sequencer
(
	input  wire  clkcms,
	input  wire  clr0,
	input  wire  ready_i,
	output logic fpga_rst_o,
	output logic holdoff_o,
	output logic ctrl_ready_o
);

	// Counter reload values, one per timed state
	localparam logic [`DMB_CNT_W-1:0] RST_LOAD  = `DMB_CNT_W'(`DMB_FPGARST_CYCLES - 1);
	localparam logic [`DMB_CNT_W-1:0] CRDY_LOAD = `DMB_CNT_W'(`DMB_CRDY_CYCLES - 1);
	localparam logic [`DMB_CNT_W-1:0] POH_LOAD  =
		`DMB_CNT_W'(`DMB_POH_CYCLES - `DMB_CRDY_CYCLES - 1);

	logic                       rdy_s1;
	logic                       rdy_s2;
	logic                       rdy_s3;
	logic                       rdy_rise;
	logic [`DMB_CNT_W-1:0]      cnt;
	dmb_trig_pkg::startup_state_t state;

	// Board ready synchroniser and edge
	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			rdy_s1 <= 1'b0;
			rdy_s2 <= 1'b0;
			rdy_s3 <= 1'b0;
		end
		else
		begin
			rdy_s1 <= ready_i;
			rdy_s2 <= rdy_s1;
			rdy_s3 <= rdy_s2;
		end
	end

	assign rdy_rise = rdy_s2 & ~rdy_s3;

	////////////////////////////////////////
	// Sequence FSM
	////////////////////////////////////////

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			state        <= dmb_trig_pkg::wait_ready;
			cnt          <= '0;
			fpga_rst_o   <= 1'b0;
			holdoff_o    <= 1'b0;
			ctrl_ready_o <= 1'b0;
		end
		else if (state != dmb_trig_pkg::wait_ready && !rdy_s2)
		begin
			// Board dropped ready, start over
			state        <= dmb_trig_pkg::wait_ready;
			fpga_rst_o   <= 1'b0;
			holdoff_o    <= 1'b0;
			ctrl_ready_o <= 1'b0;
		end
		else
		begin
			case (state)
				dmb_trig_pkg::wait_ready:
					if (rdy_rise)
					begin
						state      <= dmb_trig_pkg::fpga_rst;
						cnt        <= RST_LOAD;
						fpga_rst_o <= 1'b1;
						holdoff_o  <= 1'b1;
					end
				dmb_trig_pkg::fpga_rst:
					if (cnt == '0)
					begin
						state      <= dmb_trig_pkg::wait_crdy;
						cnt        <= CRDY_LOAD;
						fpga_rst_o <= 1'b0;
					end
					else
						cnt <= cnt - 1'b1;
				dmb_trig_pkg::wait_crdy:
					if (cnt == '0)
					begin
						state        <= dmb_trig_pkg::holdoff;
						cnt          <= POH_LOAD;
						ctrl_ready_o <= 1'b1;
					end
					else
						cnt <= cnt - 1'b1;
				dmb_trig_pkg::holdoff:
					if (cnt == '0)
					begin
						state     <= dmb_trig_pkg::run;
						holdoff_o <= 1'b0;
					end
					else
						cnt <= cnt - 1'b1;
				default:
					state <= dmb_trig_pkg::run;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/trg_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module trg_timer
(
	input  wire                     clkcms,
	input  wire                     clr0,
	input  wire                     holdoff_i,
	input  wire                     clr_i,
	input  wire                     start_i,
	input  wire                     stop_i,
	output dmb_trig_pkg::lct_time_t time_o
);

	logic                    running;
	dmb_trig_pkg::lct_time_t count;
	dmb_trig_pkg::lct_time_t time_q;

	////////////////////////////////////////
	// Interval counter
	////////////////////////////////////////

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			running <= 1'b0;
			count   <= '0;
			time_q  <= '0;
		end
		else if (clr_i)
		begin
			// Readout clear also drops a measurement in progress
			running <= 1'b0;
			count   <= '0;
			time_q  <= '0;
		end
		else if (running)
		begin
			if (stop_i)
			begin
				running <= 1'b0;
				time_q  <= count;
			end
			else if (count != '1)
				count <= count + 1'b1;
		end
		else if (start_i && !holdoff_i)
		begin
			// First cycle after the start pulse counts as one
			running <= 1'b1;
			count   <= dmb_trig_pkg::lct_time_t'(1);
		end
	end

	assign time_o = time_q;

endmodule

`default_nettype wire

// ==== source/trig_input_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module trig_input_stage
(
	input  wire                      clkcms,
	input  wire                      fpga_rst_i,
	input  dmb_trig_pkg::cfeb_mask_t pre_lct_i,
	input  dmb_trig_pkg::cfeb_mask_t l1a_match_i,
	input  dmb_trig_pkg::cfeb_mask_t cfeb_en_i,
	input  wire                      l1a_i,
	output dmb_trig_pkg::cfeb_mask_t lct_pulse_o,
	output dmb_trig_pkg::cfeb_mask_t match_o,
	output logic                     l1a_o,
	output logic                     lct_any_o
);

	dmb_trig_pkg::cfeb_mask_t pre_q;
	dmb_trig_pkg::cfeb_mask_t match_q;
	dmb_trig_pkg::cfeb_mask_t en_q;
	dmb_trig_pkg::cfeb_mask_t pre_m;
	dmb_trig_pkg::cfeb_mask_t pre_m_d;

	// Pin capture, one cycle
	always_ff @(posedge clkcms or posedge fpga_rst_i)
	begin
		if (fpga_rst_i)
		begin
			pre_q   <= '0;
			match_q <= '0;
			en_q    <= '0;
			l1a_o   <= 1'b0;
			pre_m_d <= '0;
		end
		else
		begin
			pre_q   <= pre_lct_i;
			match_q <= l1a_match_i;
			en_q    <= cfeb_en_i;
			l1a_o   <= l1a_i;
			pre_m_d <= pre_m;
		end
	end

	// Kill mask applied after capture
	assign pre_m   = pre_q & en_q;
	assign match_o = match_q & en_q;

	// Held pretrigger gives a single pulse
	assign lct_pulse_o = pre_m & ~pre_m_d;
	assign lct_any_o   = |lct_pulse_o;

endmodule

`default_nettype wire

// ==== source/trig_output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dmb_trig_params.svh"

module trig_output_stage
(
	input  wire                                    clkcms,
	input  wire                                    clr0,
	input  wire                                    fpga_rst_i,
	input  wire                                    cable_dly_i,
	input  wire  [`DMB_N_CFEB*`DMB_CODE_W-1:0]     codes_i,
	output dmb_trig_pkg::cfeb_mask_t               trg_enc_b0_o,
	output dmb_trig_pkg::cfeb_mask_t               trg_enc_b1_o,
	output dmb_trig_pkg::cfeb_mask_t               trg_enc_b2_o
);

	// Index is the code bit, each entry holds one bit of every lane
	dmb_trig_pkg::cfeb_mask_t enc_bus [`DMB_CODE_W];
	dmb_trig_pkg::cfeb_mask_t dly_bus [`DMB_CODE_W];
	dmb_trig_pkg::cfeb_mask_t out_q   [`DMB_CODE_W];

	// Lane codes to per-bit buses
	always_comb
	begin
		for (int b = 0; b < `DMB_CODE_W; b++)
		begin
			for (int k = 0; k < `DMB_N_CFEB; k++)
				enc_bus[b][k] = codes_i[k*`DMB_CODE_W + b];
		end
	end

	////////////////////////////////////////
	// Cable delay and output registers
	////////////////////////////////////////

	always_ff @(posedge clkcms or posedge clr0)
	begin
		if (clr0)
		begin
			for (int b = 0; b < `DMB_CODE_W; b++)
			begin
				dly_bus[b] <= '0;
				out_q[b]   <= '0;
			end
		end
		else if (fpga_rst_i)
		begin
			for (int b = 0; b < `DMB_CODE_W; b++)
			begin
				dly_bus[b] <= '0;
				out_q[b]   <= '0;
			end
		end
		else
		begin
			for (int b = 0; b < `DMB_CODE_W; b++)
			begin
				dly_bus[b] <= enc_bus[b];
				out_q[b]   <= cable_dly_i ? dly_bus[b] : enc_bus[b];
			end
		end
	end

	assign trg_enc_b0_o = out_q[0];
	assign trg_enc_b1_o = out_q[1];
	assign trg_enc_b2_o = out_q[2];

endmodule

`default_nettype wire

// ==== verification/tb_dmb_trig_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dmb_trig_params.svh"

module tb_dmb_trig_ctrl;

	localparam int          CLK_PERIOD = 10;
	localparam logic [31:0] LFSR_SEED  = 32'h9430_43de;
	// Rough cycle budget of all tests
	localparam int TEST_CYCLES = (`DMB_FPGARST_CYCLES + `DMB_CRDY_CYCLES + 8)
		+ (`DMB_POH_CYCLES + 4 * 56) + 3 * 64;
	localparam int WATCHDOG_NS = (TEST_CYCLES + 1000) * CLK_PERIOD;

	logic                      clkcms;
	logic                      clr0;
	logic                      ready_i;
	logic                      encode_i;
	logic                      cable_dly_i;
	logic                      readout_clr_i;
	logic                      l1a_i;
	dmb_trig_pkg::cfeb_mask_t  pre_lct_i;
	dmb_trig_pkg::cfeb_mask_t  l1a_match_i;
	dmb_trig_pkg::cfeb_mask_t  cfeb_en_i;
	dmb_trig_pkg::cfeb_mask_t  trg_enc_b0_o;
	dmb_trig_pkg::cfeb_mask_t  trg_enc_b1_o;
	dmb_trig_pkg::cfeb_mask_t  trg_enc_b2_o;
	logic                      ctrl_ready_o;
	dmb_trig_pkg::lct_time_t   lct_time_o;

	int          errors;
	int          checks;
	logic [31:0] lfsr;

	// Pin stimulus and expected outputs, one entry per cycle
	dmb_trig_pkg::cfeb_mask_t q_pre[$];
	dmb_trig_pkg::cfeb_mask_t q_match[$];
	dmb_trig_pkg::cfeb_mask_t q_en[$];
	logic                     q_l1a[$];
	dmb_trig_pkg::cfeb_mask_t q_e0[$];
	dmb_trig_pkg::cfeb_mask_t q_e1[$];
	dmb_trig_pkg::cfeb_mask_t q_e2[$];

	dmb_trig_ctrl u_dmb_trig_ctrl
	(
		.clkcms        (clkcms),
		.clr0          (clr0),
		.ready_i       (ready_i),
		.encode_i      (encode_i),
		.cable_dly_i   (cable_dly_i),
		.readout_clr_i (readout_clr_i),
		.l1a_i         (l1a_i),
		.pre_lct_i     (pre_lct_i),
		.l1a_match_i   (l1a_match_i),
		.cfeb_en_i     (cfeb_en_i),
		.trg_enc_b0_o  (trg_enc_b0_o),
		.trg_enc_b1_o  (trg_enc_b1_o),
		.trg_enc_b2_o  (trg_enc_b2_o),
		.ctrl_ready_o  (ctrl_ready_o),
		.lct_time_o    (lct_time_o)
	);

	initial
	begin
		clkcms = 1'b0;
		forever
			#(CLK_PERIOD / 2) clkcms = ~clkcms;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
		$display("Some tests failed");
		$finish;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("error %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clkcms);
		#1;
	endtask

	task automatic drive_idle();
		pre_lct_i   = '0;
		l1a_match_i = '0;
		l1a_i       = 1'b0;
	endtask

	task automatic add_stim(input dmb_trig_pkg::cfeb_mask_t pre,
		input dmb_trig_pkg::cfeb_mask_t match, input logic l1a,
		input dmb_trig_pkg::cfeb_mask_t en, input dmb_trig_pkg::cfeb_mask_t e0,
		input dmb_trig_pkg::cfeb_mask_t e1, input dmb_trig_pkg::cfeb_mask_t e2);
		q_pre.push_back(pre);
		q_match.push_back(match);
		q_l1a.push_back(l1a);
		q_en.push_back(en);
		q_e0.push_back(e0);
		q_e1.push_back(e1);
		q_e2.push_back(e2);
	endtask

	// Feeds one item per cycle and checks each output lat cycles later
	task automatic run_stream(input string name, input int lat);
		int n;
		n = q_pre.size();
		for (int i = 0; i < n + lat; i++)
		begin
			if (i >= lat)
			begin
				check($sformatf("%s b0 item %0d", name, i - lat),
					32'(q_e0[i - lat]), 32'(trg_enc_b0_o));
				check($sformatf("%s b1 item %0d", name, i - lat),
					32'(q_e1[i - lat]), 32'(trg_enc_b1_o));
				check($sformatf("%s b2 item %0d", name, i - lat),
					32'(q_e2[i - lat]), 32'(trg_enc_b2_o));
			end
			else
			begin
				// Nothing may arrive before the latency
				check($sformatf("%s early %0d", name, i), 32'h0,
					32'({trg_enc_b2_o, trg_enc_b1_o, trg_enc_b0_o}));
			end
			if (i < n)
			begin
				pre_lct_i   = q_pre[i];
				l1a_match_i = q_match[i];
				l1a_i       = q_l1a[i];
				cfeb_en_i   = q_en[i];
			end
			else
				drive_idle();
			next_cycle();
		end
		q_pre.delete();
		q_match.delete();
		q_l1a.delete();
		q_en.delete();
		q_e0.delete();
		q_e1.delete();
		q_e2.delete();
	endtask

	// Directed items, all boards enabled unless noted
	task automatic build_encode_stimulus();
		add_stim(5'b10101, 5'b00000, 1'b0, 5'b11111, 5'b10101, 5'b00000, 5'b00000);
		// Held pretrigger gives no second code
		add_stim(5'b10101, 5'b00000, 1'b0, 5'b11111, 5'b00000, 5'b00000, 5'b00000);
		add_stim(5'b10101, 5'b00000, 1'b0, 5'b11111, 5'b00000, 5'b00000, 5'b00000);
		add_stim(5'b00000, 5'b00000, 1'b1, 5'b11111, 5'b00000, 5'b00000, 5'b11111);
		add_stim(5'b00000, 5'b01011, 1'b1, 5'b11111, 5'b01011, 5'b00000, 5'b11111);
		// Match without L1A encodes as nothing
		add_stim(5'b00000, 5'b11111, 1'b0, 5'b11111, 5'b00000, 5'b00000, 5'b00000);
		add_stim(5'b11111, 5'b00000, 1'b0, 5'b11111, 5'b11111, 5'b00000, 5'b00000);
		add_stim(5'b00000, 5'b00000, 1'b0, 5'b11111, 5'b00000, 5'b00000, 5'b00000);
		// L1A outranks a pretrigger
		add_stim(5'b01010, 5'b00000, 1'b1, 5'b11111, 5'b00000, 5'b00000, 5'b11111);
		add_stim(5'b00000, 5'b00000, 1'b0, 5'b11111, 5'b00000, 5'b00000, 5'b00000);
		// Board 4 killed
		add_stim(5'b11111, 5'b00000, 1'b0, 5'b01111, 5'b01111, 5'b00000, 5'b00000);
		add_stim(5'b00000, 5'b11111, 1'b1, 5'b01111, 5'b01111, 5'b00000, 5'b11111);
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic test_startup();
		int n;
		int lo;
		int hi;
		lo = `DMB_FPGARST_CYCLES + `DMB_CRDY_CYCLES;
		hi = lo + 4;
		check("startup ctrl_ready", 32'h0, 32'(ctrl_ready_o));
		check("startup trg_enc", 32'h0,
			32'({trg_enc_b2_o, trg_enc_b1_o, trg_enc_b0_o}));
		ready_i = 1'b1;
		n = 0;
		while (!ctrl_ready_o && n <= hi)
		begin
			next_cycle();
			n++;
		end
		if (!ctrl_ready_o)
		begin
			errors++;
			$display("Controller ready never rose within %0d cycles of board ready", hi);
		end
		else if (n < lo || n > hi)
		begin
			errors++;
			$display("error startup expected %0d to %0d cycles actual %0d", lo, hi, n);
		end
	endtask

	task automatic measure_latency(input int n_cyc);
		readout_clr_i = 1'b1;
		next_cycle();
		readout_clr_i = 1'b0;
		check("timer clear", 32'h0, 32'(lct_time_o));
		next_cycle();
		pre_lct_i = 5'b00100;
		repeat (n_cyc)
			next_cycle();
		pre_lct_i = '0;
		l1a_i     = 1'b1;
		next_cycle();
		l1a_i = 1'b0;
		check($sformatf("timer early n=%0d", n_cyc), 32'h0, 32'(lct_time_o));
		next_cycle();
		check($sformatf("timer n=%0d", n_cyc), 32'(n_cyc), 32'(lct_time_o));
		next_cycle();
	endtask

	// Starts while the power-on holdoff is still active
	task automatic test_latency_timer();
		int n_cyc;
		cfeb_en_i = '1;
		pre_lct_i = 5'b00001;
		repeat (4)
			next_cycle();
		pre_lct_i = '0;
		l1a_i     = 1'b1;
		next_cycle();
		l1a_i = 1'b0;
		repeat (3)
			next_cycle();
		check("timer holdoff", 32'h0, 32'(lct_time_o));
		// Holdoff ends POH minus CRDY cycles after controller ready
		repeat (`DMB_POH_CYCLES - `DMB_CRDY_CYCLES)
			next_cycle();
		for (int t = 0; t < 3; t++)
		begin
			n_cyc = 1 + int'(rand_bits(6)) % 40;
			measure_latency(n_cyc);
		end
		readout_clr_i = 1'b1;
		next_cycle();
		readout_clr_i = 1'b0;
		check("timer final clear", 32'h0, 32'(lct_time_o));
	endtask

	task automatic test_encoding();
		encode_i    = 1'b1;
		cable_dly_i = 1'b0;
		cfeb_en_i   = '1;
		drive_idle();
		repeat (4)
			next_cycle();
		build_encode_stimulus();
		run_stream("encode", 3);
	endtask

	task automatic test_raw_mask();
		dmb_trig_pkg::cfeb_mask_t pre;
		dmb_trig_pkg::cfeb_mask_t match;
		dmb_trig_pkg::cfeb_mask_t en;
		dmb_trig_pkg::cfeb_mask_t prev;
		dmb_trig_pkg::cfeb_mask_t edge_bits;
		logic                     l1a;
		encode_i  = 1'b0;
		cfeb_en_i = '1;
		drive_idle();
		repeat (4)
			next_cycle();
		prev = '0;
		for (int i = 0; i < 40; i++)
		begin
			en        = dmb_trig_pkg::cfeb_mask_t'(rand_bits(`DMB_N_CFEB));
			pre       = dmb_trig_pkg::cfeb_mask_t'(rand_bits(`DMB_N_CFEB));
			match     = dmb_trig_pkg::cfeb_mask_t'(rand_bits(`DMB_N_CFEB));
			l1a       = rand_bits(1) != 0;
			// Leading edge of the masked pretrigger
			edge_bits = (pre & en) & ~prev;
			prev      = pre & en;
			// L1A is common to all boards and is not masked
			add_stim(pre, match, l1a, en, edge_bits, match & en, {`DMB_N_CFEB{l1a}});
		end
		run_stream("raw", 3);
		encode_i  = 1'b1;
		cfeb_en_i = '1;
	endtask

	task automatic test_cable_delay();
		encode_i    = 1'b1;
		cable_dly_i = 1'b1;
		cfeb_en_i   = '1;
		drive_idle();
		repeat (4)
			next_cycle();
		build_encode_stimulus();
		run_stream("cable", 4);
		cable_dly_i = 1'b0;
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		errors        = 0;
		checks        = 0;
		lfsr          = LFSR_SEED;
		clr0          = 1'b1;
		ready_i       = 1'b0;
		encode_i      = 1'b1;
		cable_dly_i   = 1'b0;
		readout_clr_i = 1'b0;
		l1a_i         = 1'b0;
		pre_lct_i     = '0;
		l1a_match_i   = '0;
		cfeb_en_i     = '1;

		repeat (3)
			@(posedge clkcms);
		#1;
		clr0 = 1'b0;

		test_startup();
		test_latency_timer();
		test_encoding();
		test_raw_mask();
		test_cable_delay();
		next_cycle();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
